/* src/ex_pkg.sv */
`default_nettype none

package ex_pkg;

   parameter int XLEN = 32;                       // Integer datapath width

   typedef logic [XLEN-1:0] word_t;               // Operand or result value
   typedef logic [31:0]     pc_t;                 // Instruction address
   typedef logic [5:0]      rob_id_t;             // Reorder buffer slot
   typedef logic [5:0]      preg_t;               // Physical destination register

   typedef logic [3:0] alu_op_t;                  // ALU opcode
   typedef logic [2:0] bru_op_t;                  // Branch opcode

   // ALU opcodes, shifts take opb[4:0]
   localparam alu_op_t ALU_ADD  = 4'd0;
   localparam alu_op_t ALU_SUB  = 4'd1;
   localparam alu_op_t ALU_AND  = 4'd2;
   localparam alu_op_t ALU_OR   = 4'd3;
   localparam alu_op_t ALU_XOR  = 4'd4;
   localparam alu_op_t ALU_SLL  = 4'd5;
   localparam alu_op_t ALU_SRL  = 4'd6;
   localparam alu_op_t ALU_SRA  = 4'd7;
   localparam alu_op_t ALU_SLT  = 4'd8;           // Signed compare
   localparam alu_op_t ALU_SLTU = 4'd9;           // Unsigned compare

   // Conditional codes follow funct3, jumps fill the gaps
   localparam bru_op_t BRU_BEQ  = 3'd0;
   localparam bru_op_t BRU_BNE  = 3'd1;
   localparam bru_op_t BRU_JAL  = 3'd2;
   localparam bru_op_t BRU_JALR = 3'd3;
   localparam bru_op_t BRU_BLT  = 3'd4;
   localparam bru_op_t BRU_BGE  = 3'd5;
   localparam bru_op_t BRU_BLTU = 3'd6;
   localparam bru_op_t BRU_BGEU = 3'd7;

endpackage

`default_nettype wire

/* src/ex_result_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface ex_result_if
   import ex_pkg::*;
(
   input logic clk
);
   logic    res_valid;                            // Result beat, costs one credit
   rob_id_t res_rob_id;
   preg_t   res_prd;
   logic    res_prd_we;
   word_t   res_data;
   logic    res_mispred;                          // Branch lane only
   pc_t     res_redirect_pc;
   logic    res_credit;                           // One buffer slot freed

   modport source
   (
      input  clk,
      output res_valid, res_rob_id, res_prd, res_prd_we, res_data, res_mispred,
      output res_redirect_pc,
      input  res_credit
   );

   modport sink
   (
      input  clk,
      input  res_valid, res_rob_id, res_prd, res_prd_we, res_data, res_mispred,
      input  res_redirect_pc,
      output res_credit
   );

endinterface

`default_nettype wire

/* src/alu_lane.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_lane
   import ex_pkg::*;
#(
   parameter int LANE_QDEPTH = 4,
   parameter int MERGE_DEPTH = 2
)
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        issue_valid,
   input  alu_op_t     issue_op,
   input  word_t       issue_opa,
   input  word_t       issue_opb,
   input  rob_id_t     issue_rob_id,
   input  preg_t       issue_prd,
   input  logic        issue_prd_we,
   output logic        issue_credit,
   ex_result_if.source res
);
   localparam int QPW = (LANE_QDEPTH > 1) ? $clog2(LANE_QDEPTH) : 1;
   localparam int QCW = $clog2(LANE_QDEPTH + 1);
   localparam int CCW = $clog2(MERGE_DEPTH + 1);

   alu_op_t q_op  [LANE_QDEPTH];                  // Issue queue payload
   word_t   q_opa [LANE_QDEPTH];
   word_t   q_opb [LANE_QDEPTH];
   rob_id_t q_rob [LANE_QDEPTH];
   preg_t   q_prd [LANE_QDEPTH];
   logic    q_we  [LANE_QDEPTH];

   logic [QPW-1:0] wr_ptr;
   logic [QPW-1:0] rd_ptr;
   logic [QCW-1:0] q_cnt;                         // Occupied queue entries
   logic [CCW-1:0] out_cred;                      // Free merge buffer slots
   logic           deq;
   word_t          head_a;
   word_t          head_b;
   logic [4:0]     shamt;
   word_t          alu_y;

   // Head leaves only when the merge has room for it
   assign deq    = (q_cnt != '0) && (out_cred != '0);
   assign head_a = q_opa[rd_ptr];
   assign head_b = q_opb[rd_ptr];
   assign shamt  = head_b[4:0];                   // Low 5 bits only

   always_comb
   begin
      case (q_op[rd_ptr])
         ALU_ADD:  alu_y = head_a + head_b;
         ALU_SUB:  alu_y = head_a - head_b;
         ALU_AND:  alu_y = head_a & head_b;
         ALU_OR:   alu_y = head_a | head_b;
         ALU_XOR:  alu_y = head_a ^ head_b;
         ALU_SLL:  alu_y = head_a << shamt;
         ALU_SRL:  alu_y = head_a >> shamt;
         ALU_SRA:  alu_y = word_t'($signed(head_a) >>> shamt);   // Sign fill
         ALU_SLT:  alu_y = word_t'($signed(head_a) < $signed(head_b));
         ALU_SLTU: alu_y = word_t'(head_a < head_b);
         default:  alu_y = '0;                    // Unused codes
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (issue_valid)
      begin
         q_op[wr_ptr]  <= issue_op;
         q_opa[wr_ptr] <= issue_opa;
         q_opb[wr_ptr] <= issue_opb;
         q_rob[wr_ptr] <= issue_rob_id;
         q_prd[wr_ptr] <= issue_prd;
         q_we[wr_ptr]  <= issue_prd_we;
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         q_cnt         <= '0;
         out_cred      <= CCW'(MERGE_DEPTH);      // Merge starts empty
         res.res_valid <= 1'b0;
         issue_credit  <= 1'b0;
      end
      else
      begin
         if (issue_valid)
            wr_ptr <= (wr_ptr == QPW'(LANE_QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (deq)
            rd_ptr <= (rd_ptr == QPW'(LANE_QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         q_cnt         <= q_cnt + QCW'(issue_valid) - QCW'(deq);
         out_cred      <= out_cred - CCW'(deq) + CCW'(res.res_credit);
         res.res_valid <= deq;
         issue_credit  <= deq;                    // Queue slot back to issuer
      end
   end

   always_ff @(posedge clk)
   begin
      if (deq)
      begin
         res.res_data   <= alu_y;
         res.res_rob_id <= q_rob[rd_ptr];
         res.res_prd    <= q_prd[rd_ptr];
         res.res_prd_we <= q_we[rd_ptr];
      end
   end

   assign res.res_mispred     = 1'b0;             // ALU never redirects
   assign res.res_redirect_pc = '0;

endmodule

`default_nettype wire

/* src/bru_lane.sv */
`timescale 1ns/100ps
`default_nettype none

module bru_lane
   import ex_pkg::*;
#(
   parameter int LANE_QDEPTH = 4,
   parameter int MERGE_DEPTH = 2
)
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        issue_valid,
   input  bru_op_t     issue_op,
   input  word_t       issue_opa,
   input  word_t       issue_opb,
   input  word_t       issue_imm,
   input  pc_t         issue_pc,
   input  logic        issue_pred_taken,
   input  pc_t         issue_pred_tgt,
   input  rob_id_t     issue_rob_id,
   input  preg_t       issue_prd,
   input  logic        issue_prd_we,
   output logic        issue_credit,
   ex_result_if.source res
);
   localparam int QPW = (LANE_QDEPTH > 1) ? $clog2(LANE_QDEPTH) : 1;
   localparam int QCW = $clog2(LANE_QDEPTH + 1);
   localparam int CCW = $clog2(MERGE_DEPTH + 1);

   bru_op_t q_op    [LANE_QDEPTH];
   word_t   q_opa   [LANE_QDEPTH];
   word_t   q_opb   [LANE_QDEPTH];
   word_t   q_imm   [LANE_QDEPTH];
   pc_t     q_pc    [LANE_QDEPTH];
   logic    q_ptkn  [LANE_QDEPTH];                // Predicted direction
   pc_t     q_ptgt  [LANE_QDEPTH];                // Predicted target
   rob_id_t q_rob   [LANE_QDEPTH];
   preg_t   q_prd   [LANE_QDEPTH];
   logic    q_we    [LANE_QDEPTH];

   logic [QPW-1:0] wr_ptr;
   logic [QPW-1:0] rd_ptr;
   logic [QCW-1:0] q_cnt;
   logic [CCW-1:0] out_cred;                      // Free merge buffer slots
   logic           deq;
   bru_op_t        h_op;
   word_t          h_a;
   word_t          h_b;
   logic           taken;
   pc_t            target;
   pc_t            link;                          // Fall-through pc

   assign deq  = (q_cnt != '0) && (out_cred != '0);
   assign h_op = q_op[rd_ptr];
   assign h_a  = q_opa[rd_ptr];
   assign h_b  = q_opb[rd_ptr];
   assign link = q_pc[rd_ptr] + 32'd4;

   // jalr target from register, bit 0 dropped
   assign target = (h_op == BRU_JALR) ? ((h_a + q_imm[rd_ptr]) & ~32'd1)
                                      : q_pc[rd_ptr] + q_imm[rd_ptr];

   always_comb
   begin
      case (h_op)
         BRU_BEQ:  taken = (h_a == h_b);
         BRU_BNE:  taken = (h_a != h_b);
         BRU_BLT:  taken = ($signed(h_a) < $signed(h_b));
         BRU_BGE:  taken = ($signed(h_a) >= $signed(h_b));
         BRU_BLTU: taken = (h_a < h_b);
         BRU_BGEU: taken = (h_a >= h_b);
         default:  taken = 1'b1;                  // jal and jalr
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (issue_valid)
      begin
         q_op[wr_ptr]   <= issue_op;
         q_opa[wr_ptr]  <= issue_opa;
         q_opb[wr_ptr]  <= issue_opb;
         q_imm[wr_ptr]  <= issue_imm;
         q_pc[wr_ptr]   <= issue_pc;
         q_ptkn[wr_ptr] <= issue_pred_taken;
         q_ptgt[wr_ptr] <= issue_pred_tgt;
         q_rob[wr_ptr]  <= issue_rob_id;
         q_prd[wr_ptr]  <= issue_prd;
         q_we[wr_ptr]   <= issue_prd_we;
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         q_cnt         <= '0;
         out_cred      <= CCW'(MERGE_DEPTH);
         res.res_valid <= 1'b0;
         issue_credit  <= 1'b0;
      end
      else
      begin
         if (issue_valid)
            wr_ptr <= (wr_ptr == QPW'(LANE_QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (deq)
            rd_ptr <= (rd_ptr == QPW'(LANE_QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         q_cnt         <= q_cnt + QCW'(issue_valid) - QCW'(deq);
         out_cred      <= out_cred - CCW'(deq) + CCW'(res.res_credit);
         res.res_valid <= deq;
         issue_credit  <= deq;
      end
   end

   always_ff @(posedge clk)
   begin
      if (deq)
      begin
         res.res_data        <= (h_op == BRU_JAL || h_op == BRU_JALR) ? link : '0;
         // Wrong direction, or taken to the wrong place
         res.res_mispred     <= (taken != q_ptkn[rd_ptr]) ||
                                (taken && (target != q_ptgt[rd_ptr]));
         res.res_redirect_pc <= taken ? target : link;
         res.res_rob_id      <= q_rob[rd_ptr];
         res.res_prd         <= q_prd[rd_ptr];
         res.res_prd_we      <= q_we[rd_ptr];
      end
   end

endmodule

`default_nettype wire

/* src/wb_merge.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_merge
   import ex_pkg::*;
#(
   parameter int MERGE_DEPTH = 2,
   parameter int WB_CREDITS  = 4
)
(
   input  logic      clk,
   input  logic      arst_n,
   ex_result_if.sink alu_res,
   ex_result_if.sink bru_res,
   output logic      wb_valid,
   output rob_id_t   wb_rob_id,
   output preg_t     wb_prd,
   output logic      wb_prd_we,
   output word_t     wb_data,
   output logic      wb_mispred,
   output pc_t       wb_redirect_pc,
   input  logic      wb_credit
);
   localparam int ENT_W = $bits(rob_id_t) + $bits(preg_t) + 1 + $bits(word_t) + 1
                        + $bits(pc_t);            // Packed result entry
   localparam int BPW   = (MERGE_DEPTH > 1) ? $clog2(MERGE_DEPTH) : 1;
   localparam int BCW   = $clog2(MERGE_DEPTH + 1);
   localparam int WCW   = $clog2(WB_CREDITS + 1);

   logic [1:0]       in_valid;                    // Bit 0 ALU, bit 1 branch
   logic [ENT_W-1:0] in_ent   [2];
   logic [ENT_W-1:0] head_ent [2];
   logic [1:0]       not_empty;
   logic [1:0]       grant;
   logic             last_bru;                    // Branch lane won last
   logic [WCW-1:0]   wb_cred;                     // Outbound credits held
   logic             can_send;

   assign in_valid  = {bru_res.res_valid, alu_res.res_valid};
   assign in_ent[0] = {alu_res.res_rob_id, alu_res.res_prd, alu_res.res_prd_we,
                       alu_res.res_data, alu_res.res_mispred, alu_res.res_redirect_pc};
   assign in_ent[1] = {bru_res.res_rob_id, bru_res.res_prd, bru_res.res_prd_we,
                       bru_res.res_data, bru_res.res_mispred, bru_res.res_redirect_pc};

   for (genvar i = 0; i < 2; i++)
   begin : g_buf
      logic [ENT_W-1:0] mem [MERGE_DEPTH];        // Per-lane result FIFO
      logic [BPW-1:0]   wr_ptr;
      logic [BPW-1:0]   rd_ptr;
      logic [BCW-1:0]   cnt;

      always_ff @(posedge clk)
      begin
         if (in_valid[i])
            mem[wr_ptr] <= in_ent[i];
      end

      always_ff @(posedge clk or negedge arst_n)
      begin
         if (!arst_n)
         begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
         end
         else
         begin
            if (in_valid[i])
               wr_ptr <= (wr_ptr == BPW'(MERGE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (grant[i])
               rd_ptr <= (rd_ptr == BPW'(MERGE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            cnt <= cnt + BCW'(in_valid[i]) - BCW'(grant[i]);
         end
      end

      assign head_ent[i]  = mem[rd_ptr];
      assign not_empty[i] = (cnt != '0);
   end

   // Round robin, other lane wins a tie
   assign can_send = (wb_cred != '0);
   assign grant[0] = can_send && not_empty[0] && (!not_empty[1] || last_bru);
   assign grant[1] = can_send && not_empty[1] && (!not_empty[0] || !last_bru);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wb_valid           <= 1'b0;
         wb_cred            <= WCW'(WB_CREDITS);
         last_bru           <= 1'b1;              // ALU first after reset
         alu_res.res_credit <= 1'b0;
         bru_res.res_credit <= 1'b0;
      end
      else
      begin
         wb_valid           <= |grant;
         wb_cred            <= wb_cred - WCW'(|grant) + WCW'(wb_credit);
         alu_res.res_credit <= grant[0];          // Slot freed this edge
         bru_res.res_credit <= grant[1];
         if (|grant)
            last_bru <= grant[1];
      end
   end

   always_ff @(posedge clk)
   begin
      if (|grant)
         {wb_rob_id, wb_prd, wb_prd_we, wb_data, wb_mispred, wb_redirect_pc} <=
            grant[1] ? head_ent[1] : head_ent[0];
   end

endmodule

`default_nettype wire

/* src/ex_cluster.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_cluster
   import ex_pkg::*;
#(
   parameter int LANE_QDEPTH = 4,                 // Issue credits per lane
   parameter int MERGE_DEPTH = 2,                 // Merge slots per lane
   parameter int WB_CREDITS  = 4                  // Writeback credits
)
(
   input  logic    clk,
   input  logic    arst_n,
   // ALU issue
   input  logic    alu_issue_valid,
   input  alu_op_t alu_issue_op,
   input  word_t   alu_issue_opa,
   input  word_t   alu_issue_opb,
   input  rob_id_t alu_issue_rob_id,
   input  preg_t   alu_issue_prd,
   input  logic    alu_issue_prd_we,
   output logic    alu_credit,
   // Branch issue
   input  logic    bru_issue_valid,
   input  bru_op_t bru_issue_op,
   input  word_t   bru_issue_opa,
   input  word_t   bru_issue_opb,
   input  word_t   bru_issue_imm,
   input  pc_t     bru_issue_pc,
   input  logic    bru_issue_pred_taken,
   input  pc_t     bru_issue_pred_tgt,
   input  rob_id_t bru_issue_rob_id,
   input  preg_t   bru_issue_prd,
   input  logic    bru_issue_prd_we,
   output logic    bru_credit,
   // To ROB and register file
   output logic    wb_valid,
   output rob_id_t wb_rob_id,
   output preg_t   wb_prd,
   output logic    wb_prd_we,
   output word_t   wb_data,
   output logic    wb_mispred,
   output pc_t     wb_redirect_pc,
   input  logic    wb_credit
);

   ex_result_if u_alu_res (.clk(clk));            // ALU lane to merge
   ex_result_if u_bru_res (.clk(clk));            // Branch lane to merge

   alu_lane #(
      .LANE_QDEPTH (LANE_QDEPTH),
      .MERGE_DEPTH (MERGE_DEPTH)
   ) u_alu_lane (
      .clk          (clk),
      .arst_n       (arst_n),
      .issue_valid  (alu_issue_valid),
      .issue_op     (alu_issue_op),
      .issue_opa    (alu_issue_opa),
      .issue_opb    (alu_issue_opb),
      .issue_rob_id (alu_issue_rob_id),
      .issue_prd    (alu_issue_prd),
      .issue_prd_we (alu_issue_prd_we),
      .issue_credit (alu_credit),
      .res          (u_alu_res.source)
   );

   bru_lane #(
      .LANE_QDEPTH (LANE_QDEPTH),
      .MERGE_DEPTH (MERGE_DEPTH)
   ) u_bru_lane (
      .clk              (clk),
      .arst_n           (arst_n),
      .issue_valid      (bru_issue_valid),
      .issue_op         (bru_issue_op),
      .issue_opa        (bru_issue_opa),
      .issue_opb        (bru_issue_opb),
      .issue_imm        (bru_issue_imm),
      .issue_pc         (bru_issue_pc),
      .issue_pred_taken (bru_issue_pred_taken),
      .issue_pred_tgt   (bru_issue_pred_tgt),
      .issue_rob_id     (bru_issue_rob_id),
      .issue_prd        (bru_issue_prd),
      .issue_prd_we     (bru_issue_prd_we),
      .issue_credit     (bru_credit),
      .res              (u_bru_res.source)
   );

   wb_merge #(
      .MERGE_DEPTH (MERGE_DEPTH),
      .WB_CREDITS  (WB_CREDITS)
   ) u_wb_merge (
      .clk            (clk),
      .arst_n         (arst_n),
      .alu_res        (u_alu_res.sink),
      .bru_res        (u_bru_res.sink),
      .wb_valid       (wb_valid),
      .wb_rob_id      (wb_rob_id),
      .wb_prd         (wb_prd),
      .wb_prd_we      (wb_prd_we),
      .wb_data        (wb_data),
      .wb_mispred     (wb_mispred),
      .wb_redirect_pc (wb_redirect_pc),
      .wb_credit      (wb_credit)
   );

endmodule

`default_nettype wire

/* tests/ex_cluster_props.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_cluster_props
#(
   parameter int LANE_QDEPTH = 4,
   parameter int MERGE_DEPTH = 2,
   parameter int WB_CREDITS  = 4
)
(
   input wire                                 clk,
   input wire                                 arst_n,
   input wire                                 wb_valid,
   input wire [$clog2(MERGE_DEPTH + 1)-1:0] alu_out_cred,   // Lane credits toward merge
   input wire [$clog2(MERGE_DEPTH + 1)-1:0] bru_out_cred,
   input wire [$clog2(LANE_QDEPTH + 1)-1:0] alu_q_cnt,
   input wire [$clog2(LANE_QDEPTH + 1)-1:0] bru_q_cnt,
   input wire [$clog2(WB_CREDITS + 1)-1:0]  wb_cred         // Merge writeback credits
);

   a_rst_quiet: assert property (@(posedge clk) !arst_n |-> !wb_valid)
      else $error("wb_valid high during reset");

   a_alu_cred: assert property (@(posedge clk) disable iff (!arst_n)
      alu_out_cred <= MERGE_DEPTH) else $error("ALU lane credit overflow");

   a_bru_cred: assert property (@(posedge clk) disable iff (!arst_n)
      bru_out_cred <= MERGE_DEPTH) else $error("branch lane credit overflow");

   a_wb_cred: assert property (@(posedge clk) disable iff (!arst_n)
      wb_cred <= WB_CREDITS) else $error("writeback credit overflow");

   a_q_bound: assert property (@(posedge clk) disable iff (!arst_n)
      (alu_q_cnt <= LANE_QDEPTH) && (bru_q_cnt <= LANE_QDEPTH))
      else $error("issue queue overrun");

endmodule

bind ex_cluster ex_cluster_props #(
   .LANE_QDEPTH (LANE_QDEPTH),
   .MERGE_DEPTH (MERGE_DEPTH),
   .WB_CREDITS  (WB_CREDITS)
) u_props (
   .clk          (clk),
   .arst_n       (arst_n),
   .wb_valid     (wb_valid),
   .alu_out_cred (u_alu_lane.out_cred),
   .bru_out_cred (u_bru_lane.out_cred),
   .alu_q_cnt    (u_alu_lane.q_cnt),
   .bru_q_cnt    (u_bru_lane.q_cnt),
   .wb_cred      (u_wb_merge.wb_cred)
);

`default_nettype wire

/* tests/ex_cluster_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_cluster_checker
   import ex_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n,
   input  logic    wb_valid,
   input  rob_id_t wb_rob_id,
   input  preg_t   wb_prd,
   input  logic    wb_prd_we,
   input  word_t   wb_data,
   input  logic    wb_mispred,
   input  pc_t     wb_redirect_pc,
   input  logic    wb_credit,
   input  logic    alu_credit,
   input  logic    bru_credit,
   output int      n_seen,
   output int      err_val,
   output int      err_misc
);
   localparam int WB_LIMIT = 4;                   // WB_CREDITS of the DUT

   logic  exp_vld   [64];                         // Indexed by ROB id
   logic  seen      [64];
   preg_t exp_prd   [64];
   logic  exp_we    [64];
   word_t exp_data  [64];
   logic  exp_misp  [64];
   pc_t   exp_redir [64];
   int    outstanding;                            // Writebacks not yet credited
   int    alu_pulses;
   int    bru_pulses;

   initial
   begin
      for (int i = 0; i < 64; i++)
      begin
         exp_vld[i] = 1'b0;
         seen[i]    = 1'b0;
      end
      n_seen = 0;
      err_val = 0;
      err_misc = 0;
      outstanding = 0;
      alu_pulses = 0;
      bru_pulses = 0;
   end

   task automatic expect_result(input rob_id_t rob, input preg_t prd, input logic we,
                                input word_t data, input logic misp, input pc_t redir);
      exp_vld[rob]   = 1'b1;
      exp_prd[rob]   = prd;
      exp_we[rob]    = we;
      exp_data[rob]  = data;
      exp_misp[rob]  = misp;
      exp_redir[rob] = redir;
   endtask

   task automatic compare_field(input string name, input rob_id_t rob,
                                input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s rob 0x%h: got 0x%h, expected 0x%h", name, rob, got, exp);
         err_val++;
      end
   endtask

   always @(posedge clk)
   begin
      if (arst_n)
      begin
         alu_pulses  += alu_credit;
         bru_pulses  += bru_credit;
         outstanding += wb_valid;
         outstanding -= wb_credit;
         if (outstanding > WB_LIMIT)
         begin
            $display("more writebacks outstanding than writeback credits");
            err_misc++;
         end
         if (wb_valid && !exp_vld[wb_rob_id])
         begin
            $display("writeback for unexpected rob id 0x%h", wb_rob_id);
            err_misc++;
         end
         else if (wb_valid && seen[wb_rob_id])
         begin
            $display("rob id 0x%h written back twice", wb_rob_id);
            err_misc++;
         end
         else if (wb_valid)
         begin
            seen[wb_rob_id] = 1'b1;
            n_seen++;
            compare_field("wb_prd", wb_rob_id, wb_prd, exp_prd[wb_rob_id]);
            compare_field("wb_prd_we", wb_rob_id, wb_prd_we, exp_we[wb_rob_id]);
            compare_field("wb_data", wb_rob_id, wb_data, exp_data[wb_rob_id]);
            compare_field("wb_mispred", wb_rob_id, wb_mispred, exp_misp[wb_rob_id]);
            compare_field("wb_redirect_pc", wb_rob_id, wb_redirect_pc,
                          exp_redir[wb_rob_id]);
         end
      end
   end

   // Missing ids and issue credit totals
   task automatic final_check(input int alu_n, input int bru_n);
      for (int i = 0; i < 64; i++)
      begin
         if (exp_vld[i] && !seen[i])
         begin
            $display("rob id 0x%h never written back", i[5:0]);
            err_misc++;
         end
      end
      if (alu_pulses != alu_n || bru_pulses != bru_n)
      begin
         $display("issue credits returned do not match operations issued");
         err_misc++;
      end
   endtask

endmodule

`default_nettype wire

/* tests/ex_cluster_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_cluster_tb
   import ex_pkg::*;
();
   localparam int NROWS    = 16;
   localparam int WAIT_MAX = 400;                 // Cycles allowed per wait

   logic    clk;
   logic    arst_n;
   logic    alu_issue_valid;
   alu_op_t alu_issue_op;
   word_t   alu_issue_opa;
   word_t   alu_issue_opb;
   rob_id_t alu_issue_rob_id;
   preg_t   alu_issue_prd;
   logic    alu_issue_prd_we;
   logic    alu_credit;
   logic    bru_issue_valid;
   bru_op_t bru_issue_op;
   word_t   bru_issue_opa;
   word_t   bru_issue_opb;
   word_t   bru_issue_imm;
   pc_t     bru_issue_pc;
   logic    bru_issue_pred_taken;
   pc_t     bru_issue_pred_tgt;
   rob_id_t bru_issue_rob_id;
   preg_t   bru_issue_prd;
   logic    bru_issue_prd_we;
   logic    bru_credit;
   logic    wb_valid;
   rob_id_t wb_rob_id;
   preg_t   wb_prd;
   logic    wb_prd_we;
   word_t   wb_data;
   logic    wb_mispred;
   pc_t     wb_redirect_pc;
   logic    wb_credit;

   logic       row_bru  [NROWS];                  // 1 for branch lane
   logic [3:0] row_op   [NROWS];
   word_t      row_opa  [NROWS];
   word_t      row_opb  [NROWS];
   word_t      row_imm  [NROWS];
   pc_t        row_pc   [NROWS];
   logic       row_ptkn [NROWS];
   pc_t        row_ptgt [NROWS];
   rob_id_t    row_rob  [NROWS];
   preg_t      row_prd  [NROWS];
   logic       row_we   [NROWS];

   int n_rows;
   int n_seen;
   int err_val;
   int err_misc;
   int tb_err;
   int alu_n;
   int bru_n;
   int seed;

   ex_cluster DUT (.*);

   ex_cluster_checker u_chk
   (
      .clk (clk), .arst_n (arst_n),
      .wb_valid (wb_valid), .wb_rob_id (wb_rob_id), .wb_prd (wb_prd),
      .wb_prd_we (wb_prd_we), .wb_data (wb_data), .wb_mispred (wb_mispred),
      .wb_redirect_pc (wb_redirect_pc), .wb_credit (wb_credit),
      .alu_credit (alu_credit), .bru_credit (bru_credit),
      .n_seen (n_seen), .err_val (err_val), .err_misc (err_misc)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;                         // 100 ns period

   // Stimulus row plus its hand-worked result
   task automatic add_row(input logic bru, input logic [3:0] op, input word_t opa,
                          input word_t opb, input word_t imm, input pc_t pc,
                          input logic ptkn, input pc_t ptgt, input rob_id_t rob,
                          input preg_t prd, input logic we, input word_t exp_data,
                          input logic exp_misp, input pc_t exp_redir);
      row_bru[n_rows]  = bru;
      row_op[n_rows]   = op;
      row_opa[n_rows]  = opa;
      row_opb[n_rows]  = opb;
      row_imm[n_rows]  = imm;
      row_pc[n_rows]   = pc;
      row_ptkn[n_rows] = ptkn;
      row_ptgt[n_rows] = ptgt;
      row_rob[n_rows]  = rob;
      row_prd[n_rows]  = prd;
      row_we[n_rows]   = we;
      u_chk.expect_result(rob, prd, we, exp_data, exp_misp, exp_redir);
      n_rows++;
   endtask

   task automatic load_table();
      n_rows = 0;
      add_row(0, ALU_ADD, 32'h5, 32'h7, 0, 0, 0, 0, 6'h21, 6'h01, 1, 32'hC, 0, 0);
      add_row(0, ALU_SUB, 32'h3, 32'h5, 0, 0, 0, 0, 6'h22, 6'h02, 1, 32'hFFFF_FFFE, 0, 0);
      add_row(1, BRU_BEQ, 32'h5, 32'h5, 32'h10, 32'h1000, 1, 32'h1010, 6'h2B, 6'h0B, 0,
              32'h0, 0, 32'h1010);                // Taken, predicted
      add_row(0, ALU_AND, 32'hF0F0_1234, 32'h0FF0_FF00, 0, 0, 0, 0, 6'h23, 6'h03, 1,
              32'h00F0_1200, 0, 0);
      add_row(0, ALU_OR, 32'hF000_0000, 32'hF, 0, 0, 0, 0, 6'h24, 6'h04, 0,
              32'hF000_000F, 0, 0);
      add_row(1, BRU_BNE, 32'h5, 32'h5, 32'h20, 32'h1100, 0, 32'h0, 6'h2C, 6'h0C, 0,
              32'h0, 0, 32'h1104);                // Not taken, predicted
      add_row(0, ALU_XOR, 32'hAAAA_5555, 32'hFFFF_0000, 0, 0, 0, 0, 6'h25, 6'h05, 1,
              32'h5555_5555, 0, 0);
      add_row(0, ALU_SLL, 32'h1, 32'h24, 0, 0, 0, 0, 6'h26, 6'h06, 1, 32'h10, 0, 0);
      add_row(0, ALU_SRL, 32'h8000_0000, 32'h1F, 0, 0, 0, 0, 6'h27, 6'h07, 1, 32'h1, 0, 0);
      add_row(1, BRU_BLT, 32'hFFFF_FFFF, 32'h1, 32'h40, 32'h1200, 0, 32'h0, 6'h2D, 6'h0D, 0,
              32'h0, 1, 32'h1240);                // Wrong direction
      add_row(0, ALU_SRA, 32'h8000_0000, 32'h4, 0, 0, 0, 0, 6'h28, 6'h08, 1,
              32'hF800_0000, 0, 0);
      add_row(0, ALU_SLT, 32'hFFFF_FFFF, 32'h1, 0, 0, 0, 0, 6'h29, 6'h09, 1, 32'h1, 0, 0);
      add_row(0, ALU_SLTU, 32'hFFFF_FFFF, 32'h1, 0, 0, 0, 0, 6'h2A, 6'h0A, 1, 32'h0, 0, 0);
      add_row(1, BRU_BGEU, 32'hFFFF_FFFF, 32'h1, 32'hFFFF_FFF0, 32'h1300, 1, 32'h1300,
              6'h2E, 6'h0E, 0, 32'h0, 1, 32'h12F0);   // Wrong target
      add_row(1, BRU_JAL, 32'h0, 32'h0, 32'h100, 32'h2000, 1, 32'h2100, 6'h2F, 6'h0F, 1,
              32'h2004, 0, 32'h2100);
      add_row(1, BRU_JALR, 32'h3000, 32'h0, 32'h7, 32'h2200, 1, 32'h3006, 6'h30, 6'h10, 1,
              32'h2204, 0, 32'h3006);             // Bit 0 of target dropped
   endtask

   // Writeback credits held back first, then returned after random gaps
   initial
   begin
      int outstanding;
      int gap;
      int hold;
      seed        = 59;
      outstanding = 0;
      gap         = 0;
      hold        = 0;
      forever
      begin
         @(posedge clk);
         wb_credit <= 1'b0;
         if (arst_n)
         begin
            if (wb_valid)
               outstanding++;
            if (hold < 40)
               hold++;
            else if (gap > 0)
               gap--;
            else if (outstanding > 0)
            begin
               wb_credit <= 1'b1;
               outstanding--;
               gap = $unsigned($random(seed)) % 5;
            end
         end
      end
   end

   initial
   begin
      int r;
      int wait_cnt;
      int alu_cred;
      int bru_cred;
      logic timed_out;
      arst_n = 1'b0;
      alu_issue_valid = 1'b0;
      alu_issue_op = '0;
      alu_issue_opa = '0;
      alu_issue_opb = '0;
      alu_issue_rob_id = '0;
      alu_issue_prd = '0;
      alu_issue_prd_we = 1'b0;
      bru_issue_valid = 1'b0;
      bru_issue_op = '0;
      bru_issue_opa = '0;
      bru_issue_opb = '0;
      bru_issue_imm = '0;
      bru_issue_pc = '0;
      bru_issue_pred_taken = 1'b0;
      bru_issue_pred_tgt = '0;
      bru_issue_rob_id = '0;
      bru_issue_prd = '0;
      bru_issue_prd_we = 1'b0;
      wb_credit = 1'b0;
      tb_err = 0;
      alu_n = 0;
      bru_n = 0;
      alu_cred = 4;                               // LANE_QDEPTH
      bru_cred = 4;
      timed_out = 1'b0;
      repeat (8) @(posedge clk);
      load_table();
      arst_n <= 1'b1;

      r = 0;
      wait_cnt = 0;
      while (r < n_rows && !timed_out)
      begin
         @(posedge clk);
         if (alu_credit)
            alu_cred++;
         if (bru_credit)
            bru_cred++;
         alu_issue_valid <= 1'b0;
         bru_issue_valid <= 1'b0;
         if (!row_bru[r] && alu_cred > 0)
         begin
            alu_issue_valid  <= 1'b1;
            alu_issue_op     <= row_op[r];
            alu_issue_opa    <= row_opa[r];
            alu_issue_opb    <= row_opb[r];
            alu_issue_rob_id <= row_rob[r];
            alu_issue_prd    <= row_prd[r];
            alu_issue_prd_we <= row_we[r];
            alu_cred--;
            alu_n++;
            r++;
            wait_cnt = 0;
         end
         else if (row_bru[r] && bru_cred > 0)
         begin
            bru_issue_valid      <= 1'b1;
            bru_issue_op         <= row_op[r][2:0];
            bru_issue_opa        <= row_opa[r];
            bru_issue_opb        <= row_opb[r];
            bru_issue_imm        <= row_imm[r];
            bru_issue_pc         <= row_pc[r];
            bru_issue_pred_taken <= row_ptkn[r];
            bru_issue_pred_tgt   <= row_ptgt[r];
            bru_issue_rob_id     <= row_rob[r];
            bru_issue_prd        <= row_prd[r];
            bru_issue_prd_we     <= row_we[r];
            bru_cred--;
            bru_n++;
            r++;
            wait_cnt = 0;
         end
         else
         begin
            wait_cnt++;
            if (wait_cnt > WAIT_MAX)
            begin
               $display("timeout: no issue credit came back from lane");
               timed_out = 1'b1;
               tb_err++;
            end
         end
      end
      @(posedge clk);
      alu_issue_valid <= 1'b0;
      bru_issue_valid <= 1'b0;

      // Drain every writeback, then idle a while to catch duplicates
      wait_cnt = 0;
      while (n_seen < alu_n + bru_n && wait_cnt < WAIT_MAX)
      begin
         @(posedge clk);
         wait_cnt++;
      end
      wait_cnt = 0;
      while (wait_cnt < 20)
      begin
         @(posedge clk);
         wait_cnt++;
      end
      u_chk.final_check(alu_n, bru_n);
      #1;
      $display("errors: value %0d, other %0d", err_val, err_misc + tb_err);
      if (err_val == 0 && err_misc == 0 && tb_err == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
src/ex_pkg.sv
src/ex_result_if.sv
src/alu_lane.sv
src/bru_lane.sv
src/wb_merge.sv
src/ex_cluster.sv
tests/ex_cluster_props.sv
tests/ex_cluster_checker.sv
tests/ex_cluster_tb.sv

/* Bender.yml */
package:
  name: ex_cluster

sources:
  - src/ex_pkg.sv
  - src/ex_result_if.sv
  - src/alu_lane.sv
  - src/bru_lane.sv
  - src/wb_merge.sv
  - src/ex_cluster.sv
  - target: test
    files:
      - tests/ex_cluster_props.sv
      - tests/ex_cluster_checker.sv
      - tests/ex_cluster_tb.sv
